/* hdl/controlUnit_defines.svh */
`ifndef CONTROL_UNIT_DEFINES_SVH
`define CONTROL_UNIT_DEFINES_SVH

// Instruction classes
`define CLASS_NOP    3'd0
`define CLASS_ALU    3'd1
`define CLASS_CONST  3'd2
`define CLASS_MEM    3'd4
`define CLASS_BRANCH 3'd5
`define CLASS_JUMP   3'd6

// Field positions
`define CLASS_MSB 31
`define CLASS_LSB 29
`define FUNC_MSB  28
`define FUNC_LSB  24
`define COND_MSB  25
`define COND_LSB  22

// Sub-fields inside the classes
`define MEM_STORE_BIT  24
`define CONST_MSB      25
`define CONST_LSB      24
`define BR_MSB         28
`define BR_LSB         26
`define COND_JUMP_BIT  28

// Sub-codes
`define CONST_LOADLIT 2'd0
`define CONST_LCL     2'd1
`define CONST_LCH     2'd2
`define BR_BEQ        3'd1
`define BR_BNE        3'd2
`define JMP_JUMP      5'd0
`define JMP_JAL       5'd1
`define JMP_JR        5'd2

// Special ALU operations
`define ALU_OP_ADD   5'd0
`define ALU_OP_BEQ   5'd2
`define ALU_OP_BNE   5'd7
`define ALU_OP_JUMP  5'd10
`define ALU_OP_LCH   5'd11
`define ALU_OP_LCL   5'd12
`define ALU_OP_PASSB 5'd19
`define ALU_OP_PASSA 5'd21

// Write-back and extension selects
`define WB_ALU    2'd0
`define WB_MEM    2'd1
`define WB_RET    2'd2
`define SEXT_NONE 2'd0
`define SEXT_HIGH 2'd1
`define SEXT_LOW  2'd2

// Control word after reset, strobes are active low
`define RST_BRANCH    1'b0
`define RST_MEM_READ  1'b1
`define RST_MEM_WRITE 1'b1
`define RST_MEM_TO_REG 2'd0
`define RST_ALU_OP    5'd0
`define RST_ALU_SRC   1'b0
`define RST_REG_WRITE 1'b0
`define RST_REG_B     1'b0
`define RST_JUMP_REG  1'b0
`define RST_SIGN_EXT  2'd0

`endif

/* hdl/controlPkg.sv */
`default_nettype none

package controlPkg;

	// Full instruction word as fetched
	typedef logic [31:0] instrWordT;

	// Instruction class, bits 31..29
	typedef logic [2:0] classCodeT;

	// Function field, bits 28..24
	typedef logic [4:0] funcCodeT;

	// ALU operation select
	typedef logic [4:0] aluOpT;

	// Write-back source: ALU, memory or return address
	typedef logic [1:0] memToRegT;

	// Constant extension: none, high half or low half
	typedef logic [1:0] signExtT;

	// Conditional jump condition, bits 25..22
	typedef logic [3:0] condCodeT;

endpackage

`default_nettype wire

/* hdl/opDecoder.sv */
`default_nettype none
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module opDecoder (
	input  controlPkg::instrWordT instruction,
	output logic                  known,
	output logic                  isCondJump,
	output logic                  branch,
	output logic                  memRead,
	output logic                  memWrite,
	output controlPkg::memToRegT  memToReg,
	output controlPkg::aluOpT     aluOp,
	output logic                  aluSrc,
	output logic                  regWrite,
	output logic                  registerB,
	output logic                  jumpRegister,
	output controlPkg::signExtT   opcodeSignExtend
);

	import controlPkg::*;

	classCodeT classCode;
	funcCodeT  funcCode;

	assign classCode = instruction[`CLASS_MSB:`CLASS_LSB];
	assign funcCode  = instruction[`FUNC_MSB:`FUNC_LSB];

	always_comb begin
		// Idle word, only the differing fields are set below
		known            = 1'b0;
		isCondJump       = 1'b0;
		branch           = 1'b0;
		memRead          = 1'b1;
		memWrite         = 1'b1;
		memToReg         = `WB_ALU;
		aluOp            = `ALU_OP_ADD;
		aluSrc           = 1'b0;
		regWrite         = 1'b0;
		registerB        = 1'b0;
		jumpRegister     = 1'b0;
		opcodeSignExtend = `SEXT_NONE;

		case (classCode)
			`CLASS_NOP: begin
				known = 1'b1;
			end
			`CLASS_ALU: begin
				// Codes 2, 7 and 10..15 have no ALU operation
				known    = !(funcCode inside {5'd2, 5'd7, [5'd10:5'd15]});
				aluOp    = funcCode;
				regWrite = 1'b1;
			end
			`CLASS_MEM: begin
				known  = 1'b1;
				aluSrc = 1'b1;
				if (instruction[`MEM_STORE_BIT]) begin
					memWrite  = 1'b0;
					registerB = 1'b1;
				end else begin
					memRead  = 1'b0;
					memToReg = `WB_MEM;
					regWrite = 1'b1;
				end
			end
			`CLASS_CONST: begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				case (instruction[`CONST_MSB:`CONST_LSB])
					`CONST_LOADLIT: begin
						known = 1'b1;
						aluOp = `ALU_OP_PASSB;
					end
					`CONST_LCH: begin
						known            = 1'b1;
						aluOp            = `ALU_OP_LCH;
						opcodeSignExtend = `SEXT_HIGH;
					end
					`CONST_LCL: begin
						known            = 1'b1;
						aluOp            = `ALU_OP_LCL;
						opcodeSignExtend = `SEXT_LOW;
					end
					default: known = 1'b0;
				endcase
			end
			`CLASS_BRANCH: begin
				branch    = 1'b1;
				registerB = 1'b1;
				case (instruction[`BR_MSB:`BR_LSB])
					`BR_BEQ: begin
						known = 1'b1;
						aluOp = `ALU_OP_BEQ;
					end
					`BR_BNE: begin
						known = 1'b1;
						aluOp = `ALU_OP_BNE;
					end
					default: known = 1'b0;
				endcase
			end
			`CLASS_JUMP: begin
				branch = 1'b1;
				if (instruction[`COND_JUMP_BIT]) begin
					// Branch gets replaced by the evaluated condition
					isCondJump = 1'b1;
					aluOp      = `ALU_OP_JUMP;
				end else begin
					case (funcCode)
						`JMP_JUMP: begin
							known  = 1'b1;
							aluSrc = 1'b1;
							aluOp  = `ALU_OP_JUMP;
						end
						`JMP_JAL: begin
							known    = 1'b1;
							memToReg = `WB_RET;
							regWrite = 1'b1;
						end
						`JMP_JR: begin
							known        = 1'b1;
							aluOp        = `ALU_OP_PASSA;
							jumpRegister = 1'b1;
						end
						default: known = 1'b0;
					endcase
				end
			end
			default: known = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/condEvaluator.sv */
`default_nettype none
`timescale 1ns/1ps

module condEvaluator (
	input  controlPkg::condCodeT condCode,
	input  logic                 zero,
	input  logic                 overflow,
	input  logic                 carry,
	input  logic                 neg,
	output logic                 condKnown,
	output logic                 condTaken
);

	import controlPkg::*;

	always_comb begin
		condKnown = 1'b1;
		case (condCode)
			// Jump if true
			4'd0: condTaken = zero;
			4'd1: condTaken = overflow;
			4'd2: condTaken = neg;
			4'd3: condTaken = neg | zero;
			4'd4: condTaken = carry;
			// Jump if false
			4'd5: condTaken = ~zero;
			4'd6: condTaken = ~overflow;
			4'd7: condTaken = ~neg;
			// Taken unless both flags set
			4'd8: condTaken = ~(neg & zero);
			4'd9: condTaken = ~carry;
			default: begin
				condKnown = 1'b0;
				condTaken = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/controlWordRegister.sv */
`default_nettype none
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module controlWordRegister (
	input  logic                 clock,
	input  logic                 arstN,
	input  logic                 known,
	input  logic                 isCondJump,
	input  logic                 condKnown,
	input  logic                 condTaken,
	input  logic                 candBranch,
	input  logic                 candMemRead,
	input  logic                 candMemWrite,
	input  controlPkg::memToRegT candMemToReg,
	input  controlPkg::aluOpT    candAluOp,
	input  logic                 candAluSrc,
	input  logic                 candRegWrite,
	input  logic                 candRegisterB,
	input  logic                 candJumpRegister,
	input  controlPkg::signExtT  candSignExtend,
	output logic                 branch,
	output logic                 memRead,
	output logic                 memWrite,
	output controlPkg::memToRegT memToReg,
	output controlPkg::aluOpT    aluOp,
	output logic                 aluSrc,
	output logic                 regWrite,
	output logic                 registerB,
	output logic                 jumpRegister,
	output logic                 updateB,
	output controlPkg::signExtT  opcodeSignExtend
);

	import controlPkg::*;

	logic accept;
	logic nextBranch;

	assign accept     = known | (isCondJump & condKnown);
	assign nextBranch = isCondJump ? condTaken : candBranch;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			branch           <= `RST_BRANCH;
			memRead          <= `RST_MEM_READ;
			memWrite         <= `RST_MEM_WRITE;
			memToReg         <= `RST_MEM_TO_REG;
			aluOp            <= `RST_ALU_OP;
			aluSrc           <= `RST_ALU_SRC;
			regWrite         <= `RST_REG_WRITE;
			registerB        <= `RST_REG_B;
			jumpRegister     <= `RST_JUMP_REG;
			opcodeSignExtend <= `RST_SIGN_EXT;
			updateB          <= 1'b0;
		end else if (accept) begin
			branch           <= nextBranch;
			memRead          <= candMemRead;
			memWrite         <= candMemWrite;
			memToReg         <= candMemToReg;
			aluOp            <= candAluOp;
			aluSrc           <= candAluSrc;
			regWrite         <= candRegWrite;
			registerB        <= candRegisterB;
			jumpRegister     <= candJumpRegister;
			opcodeSignExtend <= candSignExtend;
			// One toggle per accepted instruction
			updateB          <= ~updateB;
		end
	end

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
`default_nettype none
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module controlUnit (
	input  logic                  clock,
	input  logic                  arstN,
	input  controlPkg::instrWordT instruction,
	input  logic                  zero,
	input  logic                  overflow,
	input  logic                  carry,
	input  logic                  neg,
	output logic                  branch,
	output logic                  memRead,
	output logic                  memWrite,
	output controlPkg::memToRegT  memToReg,
	output controlPkg::aluOpT     aluOp,
	output logic                  aluSrc,
	output logic                  regWrite,
	output logic                  registerB,
	output logic                  jumpRegister,
	output logic                  updateB,
	output controlPkg::signExtT   opcodeSignExtend
);

	import controlPkg::*;

	logic     known;
	logic     isCondJump;
	logic     condKnown;
	logic     condTaken;
	logic     candBranch;
	logic     candMemRead;
	logic     candMemWrite;
	memToRegT candMemToReg;
	aluOpT    candAluOp;
	logic     candAluSrc;
	logic     candRegWrite;
	logic     candRegisterB;
	logic     candJumpRegister;
	signExtT  candSignExtend;

	opDecoder decoder (
		.instruction      (instruction),
		.known            (known),
		.isCondJump       (isCondJump),
		.branch           (candBranch),
		.memRead          (candMemRead),
		.memWrite         (candMemWrite),
		.memToReg         (candMemToReg),
		.aluOp            (candAluOp),
		.aluSrc           (candAluSrc),
		.regWrite         (candRegWrite),
		.registerB        (candRegisterB),
		.jumpRegister     (candJumpRegister),
		.opcodeSignExtend (candSignExtend)
	);

	// Condition field is only meaningful for conditional jumps
	condEvaluator evaluator (
		.condCode  (instruction[`COND_MSB:`COND_LSB]),
		.zero      (zero),
		.overflow  (overflow),
		.carry     (carry),
		.neg       (neg),
		.condKnown (condKnown),
		.condTaken (condTaken)
	);

	controlWordRegister wordReg (
		.clock            (clock),
		.arstN            (arstN),
		.known            (known),
		.isCondJump       (isCondJump),
		.condKnown        (condKnown),
		.condTaken        (condTaken),
		.candBranch       (candBranch),
		.candMemRead      (candMemRead),
		.candMemWrite     (candMemWrite),
		.candMemToReg     (candMemToReg),
		.candAluOp        (candAluOp),
		.candAluSrc       (candAluSrc),
		.candRegWrite     (candRegWrite),
		.candRegisterB    (candRegisterB),
		.candJumpRegister (candJumpRegister),
		.candSignExtend   (candSignExtend),
		.branch           (branch),
		.memRead          (memRead),
		.memWrite         (memWrite),
		.memToReg         (memToReg),
		.aluOp            (aluOp),
		.aluSrc           (aluSrc),
		.regWrite         (regWrite),
		.registerB        (registerB),
		.jumpRegister     (jumpRegister),
		.updateB          (updateB),
		.opcodeSignExtend (opcodeSignExtend)
	);

endmodule

`default_nettype wire

/* tests/clockGen.sv */
`default_nettype none
`timescale 1ns/1ps

module clockGen (
	output logic clock,
	output logic arstN
);

	localparam int resetCycles = 10;

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
	end

endmodule

`default_nettype wire

/* tests/controlUnitTb.sv */
`default_nettype none
`timescale 1ns/1ps

module controlUnitTb;

	import controlPkg::*;

	localparam int maxVectors = 64;
	localparam string goldenPath = "tests/controlUnit_golden.txt";

	logic      clock;
	logic      arstN;
	instrWordT instruction;
	logic      zero;
	logic      overflow;
	logic      carry;
	logic      neg;
	logic      branch;
	logic      memRead;
	logic      memWrite;
	memToRegT  memToReg;
	aluOpT     aluOp;
	logic      aluSrc;
	logic      regWrite;
	logic      registerB;
	logic      jumpRegister;
	logic      updateB;
	signExtT   opcodeSignExtend;

	// Vectors from the golden file
	instrWordT  vecInstr[maxVectors];
	logic [3:0] vecFlags[maxVectors];
	logic [7:0] vecBits[maxVectors];
	memToRegT   vecMemToReg[maxVectors];
	aluOpT      vecAluOp[maxVectors];
	signExtT    vecSignExt[maxVectors];
	string      vecName[maxVectors];
	int         vecCount = 0;
	bit         loaded = 1'b0;

	clockGen clocks (
		.clock (clock),
		.arstN (arstN)
	);

	controlUnit dut (
		.clock            (clock),
		.arstN            (arstN),
		.instruction      (instruction),
		.zero             (zero),
		.overflow         (overflow),
		.carry            (carry),
		.neg              (neg),
		.branch           (branch),
		.memRead          (memRead),
		.memWrite         (memWrite),
		.memToReg         (memToReg),
		.aluOp            (aluOp),
		.aluSrc           (aluSrc),
		.regWrite         (regWrite),
		.registerB        (registerB),
		.jumpRegister     (jumpRegister),
		.updateB          (updateB),
		.opcodeSignExtend (opcodeSignExtend)
	);

	task automatic abortRun();
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopping on first error");
	endtask

	task automatic checkBit(input string testName, input string field,
			input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %s %s: expected %0b actual %0b", testName, field, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkAluOp(input string testName, input aluOpT expected, input aluOpT actual);
		if (actual !== expected) begin
			$display("ERR %s aluOp: expected %0d actual %0d", testName, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkMemToReg(input string testName, input memToRegT expected,
			input memToRegT actual);
		if (actual !== expected) begin
			$display("ERR %s memToReg: expected %0d actual %0d", testName, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkSignExt(input string testName, input signExtT expected,
			input signExtT actual);
		if (actual !== expected) begin
			$display("ERR %s opcodeSignExtend: expected %0d actual %0d",
				testName, expected, actual);
			abortRun();
		end
	endtask

	task automatic loadGolden();
		int                fd;
		int                got;
		string             line;
		instrWordT         instr;
		logic              fz, fo, fc, fn;
		logic              eBr, eMr, eMw, eAsrc, eRw, eRb, eJr, eUpd;
		memToRegT          eM2r;
		aluOpT             eAlu;
		signExtT           eSext;
		logic [8*24-1:0]   nm;
		fd = $fopen(goldenPath, "r");
		if (fd == 0) begin
			$display("Cannot open the golden file %s", goldenPath);
			abortRun();
		end
		while (!$feof(fd)) begin
			got = $fgets(line, fd);
			// Skip comments and empty lines
			if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
				got = $sscanf(line, "%h %b %b %b %b %b %b %b %d %d %b %b %b %b %d %b %s",
					instr, fz, fo, fc, fn, eBr, eMr, eMw, eM2r, eAlu,
					eAsrc, eRw, eRb, eJr, eSext, eUpd, nm);
				if (got != 17) begin
					$display("Malformed line in the golden file: %s", line);
					abortRun();
				end
				if (vecCount >= maxVectors) begin
					$display("Golden file holds more than %0d vectors", maxVectors);
					abortRun();
				end
				vecInstr[vecCount]    = instr;
				vecFlags[vecCount]    = {fz, fo, fc, fn};
				vecBits[vecCount]     = {eBr, eMr, eMw, eAsrc, eRw, eRb, eJr, eUpd};
				vecMemToReg[vecCount] = eM2r;
				vecAluOp[vecCount]    = eAlu;
				vecSignExt[vecCount]  = eSext;
				vecName[vecCount]     = string'(nm);
				vecCount = vecCount + 1;
			end
		end
		$fclose(fd);
		if (vecCount == 0) begin
			$display("Golden file holds no vectors");
			abortRun();
		end
	endtask

	task automatic applyVector(input int idx);
		instruction = vecInstr[idx];
		{zero, overflow, carry, neg} = vecFlags[idx];
	endtask

	task automatic checkOutputs(input int idx);
		logic [7:0] bits;
		string      name;
		bits = vecBits[idx];
		name = vecName[idx];
		checkBit(name, "branch", bits[7], branch);
		checkBit(name, "memRead", bits[6], memRead);
		checkBit(name, "memWrite", bits[5], memWrite);
		checkBit(name, "aluSrc", bits[4], aluSrc);
		checkBit(name, "regWrite", bits[3], regWrite);
		checkBit(name, "registerB", bits[2], registerB);
		checkBit(name, "jumpRegister", bits[1], jumpRegister);
		checkBit(name, "updateB", bits[0], updateB);
		checkMemToReg(name, vecMemToReg[idx], memToReg);
		checkAluOp(name, vecAluOp[idx], aluOp);
		checkSignExt(name, vecSignExt[idx], opcodeSignExtend);
	endtask

	// Two cycles per vector of headroom plus reset time
	initial begin
		wait (loaded);
		#((vecCount + 20) * 8);
		$display("Watchdog expired before all vectors were checked");
		abortRun();
	end

	initial begin
		// Reserved class 7 so nothing is decoded while idle
		instruction = 32'hE000_0000;
		zero        = 1'b0;
		overflow    = 1'b0;
		carry       = 1'b0;
		neg         = 1'b0;
		loadGolden();
		loaded = 1'b1;

		@(posedge arstN);
		@(negedge clock);
		checkBit("reset", "branch", 1'b0, branch);
		checkBit("reset", "memRead", 1'b1, memRead);
		checkBit("reset", "memWrite", 1'b1, memWrite);
		checkBit("reset", "aluSrc", 1'b0, aluSrc);
		checkBit("reset", "regWrite", 1'b0, regWrite);
		checkBit("reset", "registerB", 1'b0, registerB);
		checkBit("reset", "jumpRegister", 1'b0, jumpRegister);
		checkBit("reset", "updateB", 1'b0, updateB);
		checkMemToReg("reset", '0, memToReg);
		checkAluOp("reset", '0, aluOp);
		checkSignExt("reset", '0, opcodeSignExtend);

		// One rising edge per vector
		for (int i = 0; i < vecCount; i++) begin
			applyVector(i);
			@(negedge clock);
			checkOutputs(i);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/controlUnit_golden.txt */
# instr zero overflow carry neg branch memRead memWrite memToReg aluOp aluSrc regWrite
# registerB jumpRegister signExt updateB name (instr hex, memToReg aluOp signExt decimal)
20000000 0 0 0 0 0 1 1 0 0 0 1 0 0 0 1 alu_add
21000000 0 0 0 0 0 1 1 0 1 0 1 0 0 0 0 alu_01
24000000 0 0 0 0 0 1 1 0 4 0 1 0 0 0 1 alu_04
26000000 0 0 0 0 0 1 1 0 6 0 1 0 0 0 0 alu_06
29000000 0 0 0 0 0 1 1 0 9 0 1 0 0 0 1 alu_09
30000000 0 0 0 0 0 1 1 0 16 0 1 0 0 0 0 alu_16
35000000 0 0 0 0 0 1 1 0 21 0 1 0 0 0 1 alu_21
3F000000 0 0 0 0 0 1 1 0 31 0 1 0 0 0 0 alu_31
22000000 0 0 0 0 0 1 1 0 31 0 1 0 0 0 0 alu_code2_hold
2C000000 0 0 0 0 0 1 1 0 31 0 1 0 0 0 0 alu_code12_hold
80000000 0 0 0 0 0 0 1 1 0 1 1 0 0 0 1 load
81000000 0 0 0 0 0 1 0 0 0 1 0 1 0 0 0 store
40000000 0 0 0 0 0 1 1 0 19 1 1 0 0 0 1 loadlit
42000000 0 0 0 0 0 1 1 0 11 1 1 0 0 1 0 lch
41000000 0 0 0 0 0 1 1 0 12 1 1 0 0 2 1 lcl
43000000 0 0 0 0 0 1 1 0 12 1 1 0 0 2 1 const_code3_hold
00000000 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 nop
60000000 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 class3_hold
A4000000 0 0 0 0 1 1 1 0 2 0 0 1 0 0 1 beq
A8000000 0 0 0 0 1 1 1 0 7 0 0 1 0 0 0 bne
A0000000 0 0 0 0 1 1 1 0 7 0 0 1 0 0 0 branch_code0_hold
C0000000 0 0 0 0 1 1 1 0 10 1 0 0 0 0 1 jump
C1000000 0 0 0 0 1 1 1 2 0 0 1 0 0 0 0 jal
C2000000 0 0 0 0 1 1 1 0 21 0 0 0 1 0 1 jr
C3000000 0 0 0 0 1 1 1 0 21 0 0 0 1 0 1 jump_code3_hold
E0000000 0 0 0 0 1 1 1 0 21 0 0 0 1 0 1 class7_hold
D0000000 1 0 0 0 1 1 1 0 10 0 0 0 0 0 0 jt_zero_taken
D0000000 0 1 1 1 0 1 1 0 10 0 0 0 0 0 1 jt_zero_not
D0400000 0 1 0 0 1 1 1 0 10 0 0 0 0 0 0 jt_ovf_taken
D0400000 1 0 1 1 0 1 1 0 10 0 0 0 0 0 1 jt_ovf_not
D0800000 0 0 0 1 1 1 1 0 10 0 0 0 0 0 0 jt_neg_taken
D0800000 1 1 1 0 0 1 1 0 10 0 0 0 0 0 1 jt_neg_not
D0C00000 0 0 0 1 1 1 1 0 10 0 0 0 0 0 0 jt_negzero_taken
D0C00000 0 1 1 0 0 1 1 0 10 0 0 0 0 0 1 jt_negzero_not
D1000000 0 0 1 0 1 1 1 0 10 0 0 0 0 0 0 jt_carry_taken
D1000000 1 1 0 1 0 1 1 0 10 0 0 0 0 0 1 jt_carry_not
D1400000 0 1 1 1 1 1 1 0 10 0 0 0 0 0 0 jf_zero_taken
D1400000 1 0 0 0 0 1 1 0 10 0 0 0 0 0 1 jf_zero_not
D1800000 1 0 1 1 1 1 1 0 10 0 0 0 0 0 0 jf_ovf_taken
D1800000 0 1 0 0 0 1 1 0 10 0 0 0 0 0 1 jf_ovf_not
D1C00000 1 1 1 0 1 1 1 0 10 0 0 0 0 0 0 jf_neg_taken
D1C00000 0 0 0 1 0 1 1 0 10 0 0 0 0 0 1 jf_neg_not
D2000000 0 0 0 1 1 1 1 0 10 0 0 0 0 0 0 jf_negzero_taken
D2000000 1 0 0 1 0 1 1 0 10 0 0 0 0 0 1 jf_negzero_not
D2400000 1 1 0 1 1 1 1 0 10 0 0 0 0 0 0 jf_carry_taken
D2400000 0 0 1 0 0 1 1 0 10 0 0 0 0 0 1 jf_carry_not
D3000000 1 1 1 1 0 1 1 0 10 0 0 0 0 0 1 cond_code12_hold
00000000 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 nop_after_hold

/* controlUnit.f */
+incdir+hdl
hdl/controlPkg.sv
hdl/opDecoder.sv
hdl/condEvaluator.sv
hdl/controlWordRegister.sv
hdl/controlUnit.sv
tests/clockGen.sv
tests/controlUnitTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing -j 0 --top-module controlUnitTb \
	-f controlUnit.f -o controlUnitSim \
	&& ./obj_dir/controlUnitSim \
	|| { echo "Build or simulation reported an error"; exit 1; }
